// File: include/tmu_settings.svh
/*
 * widths and register map of the blending tail.
 * included by the package and by every module that sizes a port or decodes an address.
 */
`ifndef TMU_SETTINGS_SVH
`define TMU_SETTINGS_SVH

// framebuffer word address, 1024 pixels.
`define TMU_FB_AW 10
// byte address on the register bus.
`define TMU_AXI_AW 16

// register map, byte offsets.
`define TMU_REG_CTRL 16'h0000
`define TMU_REG_ALPHA 16'h0004
`define TMU_REG_STATUS 16'h0008
`define TMU_REG_COUNT 16'h000c
// read-only pixel window, one word per 32-bit slot.
`define TMU_FB_BASE 16'h1000

`endif

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_tmu --Mdir obj_dir -o tb_tmu_sim

output=$(./obj_dir/tb_tmu_sim)
echo "$output"

if grep -q "STATUS: PASS" <<< "$output"; then
	exit 0
fi
exit 1

// File: tb.f
+incdir+include
verilog/tmu_pkg.sv
verilog/tmu_ctl.sv
verilog/tmu_fetch.sv
verilog/tmu_alpha.sv
verilog/tmu_fb.sv
verilog/tmu_top.sv
tb/tb_tmu.sv

// File: tb/tb_tmu.sv
/*
 * random-stimulus testbench of the blending tail.
 * streams fragments, drives AXI4-Lite accesses and checks FB readback
 * against a framebuffer model kept here.
 */
`default_nettype none
`include "tmu_settings.svh"

module tb_tmu;
timeunit 1ns;
timeprecision 100ps;

localparam int BURST_LEN = 32;
localparam int ROUNDS = 4;
localparam int BP_LEN = 64;
// fill, alpha rounds, held fragment and the back-pressure burst.
localparam int FRAG_TOTAL = 256 + ROUNDS * BURST_LEN + 1 + BP_LEN;
localparam int LIMIT_CYCLES = FRAG_TOTAL * 200 + 20000;

logic sys_clk;
logic sys_rst;
logic frag_stb;
logic frag_ack;
tmu_pkg::frag_t frag;
tmu_pkg::axi_req_t axi_req;
tmu_pkg::axi_rsp_t axi_rsp;

logic [31:0] lfsr = 32'h1ff9;
logic [15:0] fb_model [0:(1 << `TMU_FB_AW)-1];
logic [`TMU_FB_AW-1:0] burst_addr [$];
// all bursts land in one 256-word region.
logic [1:0] region;
logic [5:0] cur_alpha;
logic burst_done;
int value_errors;
int other_errors;

tmu_top tmu_top_i (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.frag_stb_i(frag_stb),
	.frag_ack_o(frag_ack),
	.frag_i(frag),
	.axi_req_i(axi_req),
	.axi_rsp_o(axi_rsp)
);

initial begin
	sys_clk = 1'b0;
	forever #10 sys_clk = ~sys_clk;
end

// taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken.
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	int i;
	r = '0;
	for (i = 0; i < n; i++) begin
		lfsr = lfsr_step(lfsr);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

// weights alpha+1 and 63-alpha, divide by 64, ties to even.
function automatic int blend_channel(input int a, input int t, input int d);
	int sum;
	int q;
	int rem;
	sum = (a + 1) * t + (63 - a) * d;
	q = sum / 64;
	rem = sum % 64;
	if (rem > 32 || (rem == 32 && (q % 2) == 1))
		q = q + 1;
	return q;
endfunction

function automatic logic [15:0] blend_model(input logic [5:0] a, input logic [15:0] t,
	input logic [15:0] d);
	logic [31:0] r;
	logic [31:0] g;
	logic [31:0] b;
	r = blend_channel(int'(a), int'(t[15:11]), int'(d[15:11]));
	g = blend_channel(int'(a), int'(t[10:5]), int'(d[10:5]));
	b = blend_channel(int'(a), int'(t[4:0]), int'(d[4:0]));
	return {r[4:0], g[5:0], b[4:0]};
endfunction

function automatic logic [15:0] fb_addr(input logic [`TMU_FB_AW-1:0] a);
	return `TMU_FB_BASE + (16'(a) << 2);
endfunction

// inputs change 2 ns after the edge.
task automatic step();
	@(posedge sys_clk);
	#2;
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED %s expected %h got %h", name, exp, got);
	end
endtask

task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
	int n;
	axi_req.awvalid = 1'b1;
	axi_req.awaddr = addr;
	axi_req.wvalid = 1'b1;
	axi_req.wdata = data;
	@(negedge sys_clk);
	while (!(axi_rsp.awready && axi_rsp.wready)) @(negedge sys_clk);
	step();
	axi_req.awvalid = 1'b0;
	axi_req.wvalid = 1'b0;
	n = 0;
	do begin
		@(negedge sys_clk);
		n++;
	end while (!axi_rsp.bvalid);
	if (n != 1) begin
		other_errors++;
		$display("write response came %0d cycles after the transfer, expected 1", n);
	end
	// every access answers OKAY.
	check_value("bresp", 32'd0, {30'd0, axi_rsp.bresp});
	// bready is always high.
	step();
endtask

task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
	int n;
	int lat;
	lat = (addr >= `TMU_FB_BASE) ? 2 : 1;
	axi_req.arvalid = 1'b1;
	axi_req.araddr = addr;
	@(negedge sys_clk);
	while (!axi_rsp.arready) @(negedge sys_clk);
	step();
	axi_req.arvalid = 1'b0;
	n = 0;
	do begin
		@(negedge sys_clk);
		n++;
	end while (!axi_rsp.rvalid);
	if (n != lat) begin
		other_errors++;
		$display("read data at %h came after %0d cycles, expected %0d", addr, n, lat);
	end
	check_value("rresp", 32'd0, {30'd0, axi_rsp.rresp});
	data = axi_rsp.rdata;
	step();
endtask

task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp, input string name);
	logic [31:0] v;
	axi_read(addr, v);
	check_value(name, exp, v);
endtask

task automatic check_fb(input logic [`TMU_FB_AW-1:0] a);
	read_expect(fb_addr(a), {16'd0, fb_model[a]}, $sformatf("fb[%03h]", a));
endtask

// STATUS busy low means the last pixel is in the RAM.
task automatic wait_idle();
	logic [31:0] v;
	do
		axi_read(`TMU_REG_STATUS, v);
	while (v[0]);
endtask

task automatic send_frag(input tmu_pkg::frag_t f, input int gap);
	repeat (gap) step();
	frag = f;
	frag_stb = 1'b1;
	@(negedge sys_clk);
	while (!frag_ack) @(negedge sys_clk);
	step();
	frag_stb = 1'b0;
endtask

// consecutive slots from a random offset, so no address repeats.
task automatic run_burst(input int len, input int gap_bits);
	tmu_pkg::frag_t f;
	logic [7:0] off;
	logic [7:0] slot;
	int i;
	off = 8'(rand_bits(8));
	burst_addr.delete();
	for (i = 0; i < len; i++) begin
		slot = off + 8'(i);
		f.addr = {region, slot};
		f.color = 16'(rand_bits(16));
		fb_model[f.addr] = blend_model(cur_alpha, f.color, fb_model[f.addr]);
		burst_addr.push_back(f.addr);
		send_frag(f, int'(rand_bits(gap_bits)));
	end
endtask

task automatic check_burst();
	foreach (burst_addr[i])
		check_fb(burst_addr[i]);
endtask

task automatic watch_ack_low(input int cycles);
	repeat (cycles) begin
		@(negedge sys_clk);
		if (frag_ack) begin
			other_errors++;
			$display("fragment acknowledged while the input is disabled");
		end
	end
endtask

// keeps the shared RAM port busy while a burst runs.
task automatic readback_loop();
	logic [31:0] v;
	while (!burst_done)
		axi_read(fb_addr({region, 8'(rand_bits(8))}), v);
endtask

initial begin
	repeat (LIMIT_CYCLES) @(posedge sys_clk);
	$display("watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
	$display("STATUS: FAIL");
	$finish;
end

initial begin
	int n;
	tmu_pkg::frag_t hold_frag;
	sys_rst = 1'b1;
	frag_stb = 1'b0;
	frag = '0;
	axi_req = '0;
	axi_req.bready = 1'b1;
	axi_req.rready = 1'b1;
	value_errors = 0;
	other_errors = 0;
	burst_done = 1'b0;
	cur_alpha = 6'd0;
	for (n = 0; n < (1 << `TMU_FB_AW); n++)
		fb_model[n] = 16'd0;
	repeat (8) @(posedge sys_clk);
	#2;
	sys_rst = 1'b0;

	// reset values, then masking to field widths.
	read_expect(`TMU_REG_CTRL, 32'd0, "ctrl");
	read_expect(`TMU_REG_ALPHA, 32'd0, "alpha");
	read_expect(`TMU_REG_COUNT, 32'd0, "count");
	read_expect(`TMU_REG_STATUS, 32'd0, "status");
	axi_write(`TMU_REG_CTRL, 32'hffff_ffff);
	read_expect(`TMU_REG_CTRL, 32'd1, "ctrl");
	axi_write(`TMU_REG_ALPHA, 32'hffff_ffff);
	read_expect(`TMU_REG_ALPHA, 32'h3f, "alpha");

	// alpha 63 copies the texel, fills the region.
	region = 2'(rand_bits(2));
	cur_alpha = 6'd63;
	run_burst(256, 0);
	wait_idle();
	read_expect(`TMU_REG_COUNT, 32'd256, "count");
	for (n = 0; n < 256; n++)
		check_fb({region, 8'(n)});
	axi_write(`TMU_REG_COUNT, 32'h5a5a_5a5a);
	read_expect(`TMU_REG_COUNT, 32'd0, "count");

	// random alpha, random gaps on the strobe.
	for (n = 0; n < ROUNDS; n++) begin
		cur_alpha = 6'(rand_bits(6));
		axi_write(`TMU_REG_ALPHA, {26'd0, cur_alpha});
		run_burst(BURST_LEN, 2);
		wait_idle();
		check_burst();
	end

	// held fragment while disabled.
	axi_write(`TMU_REG_COUNT, 32'd0);
	axi_write(`TMU_REG_CTRL, 32'd0);
	hold_frag.addr = {region, 8'(rand_bits(8))};
	hold_frag.color = 16'(rand_bits(16));
	n = 4 + int'(rand_bits(4));
	fork
		send_frag(hold_frag, 0);
		begin
			watch_ack_low(n);
			step();
			check_fb(hold_frag.addr);
			axi_write(`TMU_REG_CTRL, 32'd1);
		end
	join
	fb_model[hold_frag.addr] = blend_model(cur_alpha, hold_frag.color,
		fb_model[hold_frag.addr]);
	wait_idle();
	read_expect(`TMU_REG_COUNT, 32'd1, "count");
	check_fb(hold_frag.addr);

	// readbacks steal the write port during a full-rate burst.
	axi_write(`TMU_REG_COUNT, 32'd0);
	burst_done = 1'b0;
	fork
		begin
			run_burst(BP_LEN, 0);
			burst_done = 1'b1;
		end
		readback_loop();
	join
	wait_idle();
	read_expect(`TMU_REG_COUNT, 32'(BP_LEN), "count");
	check_burst();

	$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
	if (value_errors == 0 && other_errors == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog/tmu_alpha.sv
/*
 * four-stage alpha blender for RGB565 pixels.
 * per channel ((alpha+1)*texel + (63-alpha)*dest) / 64, rounded half to even.
 * whole pipe stalls when the last stage is full and not acked.
 */
`default_nettype none
`include "tmu_settings.svh"

module tmu_alpha (
	input wire sys_clk,
	input wire sys_rst,
	input wire [5:0] alpha_i,
	input wire pair_stb_i,
	output logic pair_ack_o,
	input tmu_pkg::pair_t pair_i,
	output logic px_stb_o,
	input wire px_ack_i,
	output tmu_pkg::px_t px_o,
	output logic busy_o
);

logic en;
logic [3:0] valid;
logic [6:0] wt_src;
logic [5:0] wt_dst;
logic [`TMU_FB_AW-1:0] addr_1;
logic [`TMU_FB_AW-1:0] addr_2;
logic [`TMU_FB_AW-1:0] addr_3;
logic [`TMU_FB_AW-1:0] addr_4;
// stage 1 weighted channels.
logic [10:0] r_s;
logic [11:0] g_s;
logic [10:0] b_s;
logic [10:0] r_d;
logic [11:0] g_d;
logic [10:0] b_d;
// stage 2 sums.
logic [10:0] r_sum;
logic [11:0] g_sum;
logic [10:0] b_sum;
// stage 3 quotient and round-up bit.
logic [4:0] r_q;
logic [5:0] g_q;
logic [4:0] b_q;
logic r_up;
logic g_up;
logic b_up;
// stage 4 result.
logic [4:0] r_4;
logic [5:0] g_4;
logic [4:0] b_4;

// weights add up to 64.
assign wt_src = {1'b0, alpha_i} + 7'd1;
assign wt_dst = 6'd63 - alpha_i;

always_ff @(posedge sys_clk) begin
	if (sys_rst)
		valid <= 4'd0;
	else if (en)
		valid <= {valid[2:0], pair_stb_i};
end

always_ff @(posedge sys_clk) begin
	if (en) begin
		addr_1 <= pair_i.addr;
		addr_2 <= addr_1;
		addr_3 <= addr_2;
		addr_4 <= addr_3;

		r_s <= wt_src * pair_i.tcol[15:11];
		g_s <= wt_src * pair_i.tcol[10:5];
		b_s <= wt_src * pair_i.tcol[4:0];
		r_d <= wt_dst * pair_i.dcol[15:11];
		g_d <= wt_dst * pair_i.dcol[10:5];
		b_d <= wt_dst * pair_i.dcol[4:0];

		r_sum <= r_s + r_d;
		g_sum <= g_s + g_d;
		b_sum <= b_s + b_d;

		// up if remainder above half, or exactly half with an odd quotient.
		r_q <= r_sum[10:6];
		g_q <= g_sum[11:6];
		b_q <= b_sum[10:6];
		r_up <= r_sum[5] & ((|r_sum[4:0]) | r_sum[6]);
		g_up <= g_sum[5] & ((|g_sum[4:0]) | g_sum[6]);
		b_up <= b_sum[5] & ((|b_sum[4:0]) | b_sum[6]);

		// sum never exceeds 64*max, so no carry out.
		r_4 <= r_q + {4'd0, r_up};
		g_4 <= g_q + {5'd0, g_up};
		b_4 <= b_q + {4'd0, b_up};
	end
end

assign en = ~valid[3] | px_ack_i;
assign pair_ack_o = en;

assign px_stb_o = valid[3];
assign px_o = {addr_4, r_4, g_4, b_4};

assign busy_o = |valid;

// an offered pixel is never withdrawn.
assert property (@(posedge sys_clk) disable iff (sys_rst)
	(px_stb_o && !px_ack_i) |=> px_stb_o);

endmodule

`default_nettype wire

// File: verilog/tmu_ctl.sv
/*
 * AXI4-Lite register slave of the blending tail.
 * holds enable, alpha and the written-fragment count, and reads framebuffer
 * words back through the shared RAM port. one transaction at a time.
 */
`default_nettype none
`include "tmu_settings.svh"

module tmu_ctl (
	input wire sys_clk,
	input wire sys_rst,
	input tmu_pkg::axi_req_t axi_req_i,
	output tmu_pkg::axi_rsp_t axi_rsp_o,
	input wire busy_i,
	input wire written_i,
	output logic enable_o,
	output logic [5:0] alpha_o,
	output logic fb_rd_o,
	output logic [`TMU_FB_AW-1:0] fb_raddr_o,
	input wire [15:0] fb_rdata_i
);

localparam logic [`TMU_AXI_AW-1:0] FB_BASE = `TMU_FB_BASE;

tmu_pkg::axi_st_e state;
tmu_pkg::reg_sel_e wsel;
tmu_pkg::reg_sel_e rsel;
logic wr_go;
logic rd_go;
logic [31:0] count;
logic [31:0] reg_val;
logic [31:0] rdata_q;

// upper bits select the pixel window, the rest is an exact match.
function automatic tmu_pkg::reg_sel_e decode(input logic [`TMU_AXI_AW-1:0] a);
	if (a[`TMU_AXI_AW-1:`TMU_FB_AW+2] == FB_BASE[`TMU_AXI_AW-1:`TMU_FB_AW+2])
		return tmu_pkg::FB;
	case (a)
		`TMU_REG_CTRL: return tmu_pkg::CTRL;
		`TMU_REG_ALPHA: return tmu_pkg::ALPHA;
		`TMU_REG_STATUS: return tmu_pkg::STATUS;
		`TMU_REG_COUNT: return tmu_pkg::COUNT;
		default: return tmu_pkg::NONE;
	endcase
endfunction

assign wsel = decode(axi_req_i.awaddr);
assign rsel = decode(axi_req_i.araddr);

// aw and w taken together, writes win over reads.
assign wr_go = (state == tmu_pkg::IDLE) & axi_req_i.awvalid & axi_req_i.wvalid;
assign rd_go = (state == tmu_pkg::IDLE) & axi_req_i.arvalid
	& ~(axi_req_i.awvalid & axi_req_i.wvalid);

// window read hits the RAM in the ar cycle.
assign fb_rd_o = rd_go & (rsel == tmu_pkg::FB);
assign fb_raddr_o = axi_req_i.araddr[`TMU_FB_AW+1:2];

always_comb begin
	axi_rsp_o = '0;
	axi_rsp_o.awready = wr_go;
	axi_rsp_o.wready = wr_go;
	axi_rsp_o.bvalid = (state == tmu_pkg::WRESP);
	axi_rsp_o.bresp = 2'b00;
	axi_rsp_o.arready = rd_go;
	axi_rsp_o.rvalid = (state == tmu_pkg::RRESP);
	axi_rsp_o.rdata = rdata_q;
	axi_rsp_o.rresp = 2'b00;
end

// register read mux.
always_comb begin
	case (rsel)
		tmu_pkg::CTRL: reg_val = {31'd0, enable_o};
		tmu_pkg::ALPHA: reg_val = {26'd0, alpha_o};
		tmu_pkg::STATUS: reg_val = {31'd0, busy_i};
		tmu_pkg::COUNT: reg_val = count;
		default: reg_val = 32'd0;
	endcase
end

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		state <= tmu_pkg::IDLE;
		enable_o <= 1'b0;
		alpha_o <= 6'd0;
		count <= 32'd0;
	end else begin
		// any write to COUNT clears it, ahead of a write-back in the same cycle.
		if (wr_go && (wsel == tmu_pkg::COUNT))
			count <= 32'd0;
		else if (written_i)
			count <= count + 32'd1;
		case (state)
			tmu_pkg::IDLE: begin
				if (wr_go) begin
					if (wsel == tmu_pkg::CTRL)
						enable_o <= axi_req_i.wdata[0];
					if (wsel == tmu_pkg::ALPHA)
						alpha_o <= axi_req_i.wdata[5:0];
					state <= tmu_pkg::WRESP;
				end else if (rd_go) begin
					state <= (rsel == tmu_pkg::FB) ? tmu_pkg::RFB : tmu_pkg::RRESP;
				end
			end
			tmu_pkg::WRESP: if (axi_req_i.bready) state <= tmu_pkg::IDLE;
			// RAM data lands here, one more cycle to capture.
			tmu_pkg::RFB: state <= tmu_pkg::RRESP;
			tmu_pkg::RRESP: if (axi_req_i.rready) state <= tmu_pkg::IDLE;
			default: state <= tmu_pkg::IDLE;
		endcase
	end
end

// read data, held until rready.
always_ff @(posedge sys_clk) begin
	if (rd_go)
		rdata_q <= reg_val;
	else if (state == tmu_pkg::RFB)
		rdata_q <= {16'd0, fb_rdata_i};
end

// only one response channel active.
assert property (@(posedge sys_clk) disable iff (sys_rst)
	!(axi_rsp_o.bvalid && axi_rsp_o.rvalid));

endmodule

`default_nettype wire

// File: verilog/tmu_fb.sv
/*
 * on-chip framebuffer, 16-bit words.
 * read port for the fetch stage, shared port for pixel writes and CPU readback.
 * readback takes the shared port first and holds writes off.
 */
`default_nettype none
`include "tmu_settings.svh"

module tmu_fb (
	input wire sys_clk,
	input wire [`TMU_FB_AW-1:0] rd_addr_i,
	output logic [15:0] rd_data_o,
	input wire px_stb_i,
	output logic px_ack_o,
	input tmu_pkg::px_t px_i,
	input wire cpu_rd_i,
	input wire [`TMU_FB_AW-1:0] cpu_addr_i,
	output logic [15:0] cpu_data_o,
	output logic written_o
);

logic [15:0] mem [0:(1 << `TMU_FB_AW)-1];
logic wr;

// back-pressure only while the CPU owns the port.
assign px_ack_o = ~cpu_rd_i;
assign wr = px_stb_i & px_ack_o;

// one pulse per pixel written.
assign written_o = wr;

// fetch port.
always_ff @(posedge sys_clk)
	rd_data_o <= mem[rd_addr_i];

// shared port.
always_ff @(posedge sys_clk) begin
	if (cpu_rd_i)
		cpu_data_o <= mem[cpu_addr_i];
	else if (wr)
		mem[px_i.addr] <= px_i.color;
end

endmodule

`default_nettype wire

// File: verilog/tmu_fetch.sv
/*
 * fetch stage. accepts fragments, reads the destination pixel from the
 * framebuffer and hands the texel and pixel on as one pair.
 */
`default_nettype none
`include "tmu_settings.svh"

module tmu_fetch (
	input wire sys_clk,
	input wire sys_rst,
	input wire enable_i,
	input wire frag_stb_i,
	output logic frag_ack_o,
	input tmu_pkg::frag_t frag_i,
	output logic [`TMU_FB_AW-1:0] rd_addr_o,
	input wire [15:0] rd_data_i,
	output logic pair_stb_o,
	input wire pair_ack_i,
	output tmu_pkg::pair_t pair_o,
	output logic busy_o
);

// stage 1 holds the accepted fragment and addresses the RAM.
tmu_pkg::frag_t frag_1;
logic valid_1;
// stage 2 sees the pixel on the RAM output.
tmu_pkg::frag_t frag_2;
logic valid_2;
logic adv;

// stage 2 free or draining.
assign adv = ~valid_2 | pair_ack_i;

// no input while disabled.
assign frag_ack_o = enable_i & (~valid_1 | adv);

// on a stall, re-read the waiting pixel so the RAM output holds.
assign rd_addr_o = adv ? frag_1.addr : frag_2.addr;

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		valid_1 <= 1'b0;
		valid_2 <= 1'b0;
	end else begin
		if (adv)
			valid_2 <= valid_1;
		if (frag_ack_o)
			valid_1 <= frag_stb_i;
		else if (adv)
			valid_1 <= 1'b0;
	end
end

// payload registers.
always_ff @(posedge sys_clk) begin
	if (frag_ack_o && frag_stb_i)
		frag_1 <= frag_i;
	if (adv)
		frag_2 <= frag_1;
end

assign pair_stb_o = valid_2;
assign pair_o = {frag_2.addr, frag_2.color, rd_data_i};

assign busy_o = valid_1 | valid_2;

// waiting pair must not change under the consumer.
assert property (@(posedge sys_clk) disable iff (sys_rst)
	(pair_stb_o && !pair_ack_i) |=> $stable(pair_o));

endmodule

`default_nettype wire

// File: verilog/tmu_pkg.sv
/*
 * shared types of the blending tail: stream payloads, AXI4-Lite channel bundles
 * and the enums of the control block. referenced by scoped names only.
 */
`default_nettype none
`include "tmu_settings.svh"

package tmu_pkg;

	// incoming textured fragment.
	typedef struct packed {
		logic [`TMU_FB_AW-1:0] addr;
		logic [15:0] color;
	} frag_t;

	// fragment paired with the pixel it lands on.
	typedef struct packed {
		logic [`TMU_FB_AW-1:0] addr;
		logic [15:0] tcol;
		logic [15:0] dcol;
	} pair_t;

	// blended pixel ready for write-back.
	typedef struct packed {
		logic [`TMU_FB_AW-1:0] addr;
		logic [15:0] color;
	} px_t;

	// master side, single beat only.
	typedef struct packed {
		logic awvalid;
		logic [`TMU_AXI_AW-1:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic arvalid;
		logic [`TMU_AXI_AW-1:0] araddr;
		logic bready;
		logic rready;
	} axi_req_t;

	// slave side.
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axi_rsp_t;

	typedef enum logic [2:0] {CTRL, ALPHA, STATUS, COUNT, FB, NONE} reg_sel_e;

	typedef enum logic [1:0] {IDLE, WRESP, RFB, RRESP} axi_st_e;

endpackage

`default_nettype wire

// File: verilog/tmu_top.sv
/*
 * blending tail top level.
 * fragments enter on a strobe/ack stream, registers and readback sit on AXI4-Lite.
 */
`default_nettype none
`include "tmu_settings.svh"

module tmu_top (
	input wire sys_clk,
	input wire sys_rst,
	input wire frag_stb_i,
	output logic frag_ack_o,
	input tmu_pkg::frag_t frag_i,
	input tmu_pkg::axi_req_t axi_req_i,
	output tmu_pkg::axi_rsp_t axi_rsp_o
);

logic enable;
logic [5:0] alpha;
logic [`TMU_FB_AW-1:0] rd_addr;
logic [15:0] rd_data;
tmu_pkg::pair_t pair;
logic pair_stb;
logic pair_ack;
tmu_pkg::px_t px;
logic px_stb;
logic px_ack;
logic fb_rd;
logic [`TMU_FB_AW-1:0] fb_raddr;
logic [15:0] fb_rdata;
logic written;
logic fetch_busy;
logic alpha_busy;
logic busy;

// anything still in the datapath.
assign busy = fetch_busy | alpha_busy;

tmu_ctl tmu_ctl_i (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.axi_req_i(axi_req_i),
	.axi_rsp_o(axi_rsp_o),
	.busy_i(busy),
	.written_i(written),
	.enable_o(enable),
	.alpha_o(alpha),
	.fb_rd_o(fb_rd),
	.fb_raddr_o(fb_raddr),
	.fb_rdata_i(fb_rdata)
);

tmu_fetch tmu_fetch_i (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.enable_i(enable),
	.frag_stb_i(frag_stb_i),
	.frag_ack_o(frag_ack_o),
	.frag_i(frag_i),
	.rd_addr_o(rd_addr),
	.rd_data_i(rd_data),
	.pair_stb_o(pair_stb),
	.pair_ack_i(pair_ack),
	.pair_o(pair),
	.busy_o(fetch_busy)
);

tmu_alpha tmu_alpha_i (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.alpha_i(alpha),
	.pair_stb_i(pair_stb),
	.pair_ack_o(pair_ack),
	.pair_i(pair),
	.px_stb_o(px_stb),
	.px_ack_i(px_ack),
	.px_o(px),
	.busy_o(alpha_busy)
);

tmu_fb tmu_fb_i (
	.sys_clk(sys_clk),
	.rd_addr_i(rd_addr),
	.rd_data_o(rd_data),
	.px_stb_i(px_stb),
	.px_ack_o(px_ack),
	.px_i(px),
	.cpu_rd_i(fb_rd),
	.cpu_addr_i(fb_raddr),
	.cpu_data_o(fb_rdata),
	.written_o(written)
);

endmodule

`default_nettype wire
